// ==== hdl/rv_exec_pkg.sv ====
package rv_exec_pkg;

    // Datapath and register index widths.
    localparam int XLEN       = 32;  // Data width.
    localparam int REG_ADDR_W = 5;   // Register index width.

    // Major opcodes of the two supported groups.
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,  // Register-register ops.
        OPC_OP_IMM = 7'b0010011   // Register-immediate ops.
    } opcode_e;

    // ALU operation encoding, ten codes used.
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLL  = 4'd2,
        ALU_SLT  = 4'd3,
        ALU_SLTU = 4'd4,
        ALU_XOR  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_OR   = 4'd8,
        ALU_AND  = 4'd9
    } alu_op_e;

    // R-format view of the word.
    typedef struct packed {
        logic [6:0]            funct7;  // SUB/SRA select.
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } r_fmt_t;

    // I-format view of the word.
    typedef struct packed {
        logic [11:0]           imm12;   // Signed immediate or shamt.
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } i_fmt_t;

    // One instruction word, two decodings.
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
    } instr_word_u;

    // Decode-stage payload.
    typedef struct packed {
        alu_op_e               op;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       imm;      // Sign-extended.
        logic                  use_imm;  // B operand from imm.
        logic                  illegal;  // Unsupported word.
    } decoded_op_t;

    // Downstream result record, 38 bits.
    typedef struct packed {
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       value;
        logic                  illegal;
    } result_t;

endpackage

// ==== hdl/instr_queue.sv ====
module instr_queue #(
    parameter int INSTR_DEPTH = 4
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     push_i,
    input  rv_exec_pkg::instr_word_u data_i,
    input  logic                     pop_i,
    output rv_exec_pkg::instr_word_u head_o,
    output logic                     empty_o
);
    import rv_exec_pkg::*;

    localparam int PTR_W = (INSTR_DEPTH > 1) ? $clog2(INSTR_DEPTH) : 1;
    localparam int CNT_W = $clog2(INSTR_DEPTH + 1);

    instr_word_u        mem [INSTR_DEPTH];  // Storage, no reset.
    logic [PTR_W-1:0]   wr_ptr;             // Next slot to write.
    logic [PTR_W-1:0]   rd_ptr;             // Current head slot.
    logic [CNT_W-1:0]   count;              // Occupancy.
    logic               do_pop;

    assign do_pop  = pop_i && !empty_o;  // Never pop an empty queue.
    assign empty_o = (count == '0);
    assign head_o  = mem[rd_ptr];        // Head is a plain read.

    // Payload write, credits guarantee space.
    always_ff @(posedge clk) begin
        if (push_i) begin
            mem[wr_ptr] <= data_i;
        end
    end

    // Pointers wrap at the depth, which need not be a power of two.
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr <= (wr_ptr == PTR_W'(INSTR_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(INSTR_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push_i, do_pop})
                2'b10:   count <= count + 1'b1;  // Fill.
                2'b01:   count <= count - 1'b1;  // Drain.
                default: count <= count;         // Both or neither.
            endcase
        end
    end

endmodule

// ==== hdl/instr_decoder.sv ====
module instr_decoder (
    input  rv_exec_pkg::instr_word_u instr_i,
    output rv_exec_pkg::decoded_op_t dec_o
);
    import rv_exec_pkg::*;

    logic [2:0] funct3;
    logic [6:0] funct7;
    logic [6:0] imm_hi;  // Upper imm bits, shift kind.

    assign funct3 = instr_i.r.funct3;       // Same bits in both views.
    assign funct7 = instr_i.r.funct7;
    assign imm_hi = instr_i.i.imm12[11:5];

    always_comb begin
        dec_o         = '0;
        dec_o.op      = ALU_ADD;
        dec_o.rs1     = instr_i.r.rs1;
        dec_o.rd      = instr_i.r.rd;
        dec_o.illegal = 1'b0;

        case (opcode_e'(instr_i.r.opcode))
            OPC_OP: begin
                dec_o.rs2     = instr_i.r.rs2;  // Second operand from bank.
                dec_o.use_imm = 1'b0;
                case (funct3)
                    3'b000: dec_o.op = funct7[5] ? ALU_SUB : ALU_ADD;
                    3'b001: dec_o.op = ALU_SLL;
                    3'b010: dec_o.op = ALU_SLT;
                    3'b011: dec_o.op = ALU_SLTU;
                    3'b100: dec_o.op = ALU_XOR;
                    3'b101: dec_o.op = funct7[5] ? ALU_SRA : ALU_SRL;
                    3'b110: dec_o.op = ALU_OR;
                    default: dec_o.op = ALU_AND;
                endcase
                // Only 0000000, or 0100000 on SUB/SRA.
                if (funct7 == 7'b0100000) begin
                    dec_o.illegal = !(funct3 == 3'b000 || funct3 == 3'b101);
                end else begin
                    dec_o.illegal = (funct7 != 7'b0000000);
                end
            end
            OPC_OP_IMM: begin
                dec_o.use_imm = 1'b1;
                dec_o.imm     = {{(XLEN-12){instr_i.i.imm12[11]}}, instr_i.i.imm12};
                case (funct3)
                    3'b000: dec_o.op = ALU_ADD;
                    3'b001: begin
                        dec_o.op      = ALU_SLL;
                        dec_o.illegal = (imm_hi != 7'b0000000);  // SLLI only.
                    end
                    3'b010: dec_o.op = ALU_SLT;
                    3'b011: dec_o.op = ALU_SLTU;
                    3'b100: dec_o.op = ALU_XOR;
                    3'b101: begin
                        dec_o.op      = imm_hi[5] ? ALU_SRA : ALU_SRL;
                        dec_o.illegal = (imm_hi != 7'b0000000) && (imm_hi != 7'b0100000);
                    end
                    3'b110: dec_o.op = ALU_OR;
                    default: dec_o.op = ALU_AND;
                endcase
            end
            default: begin
                dec_o.illegal = 1'b1;  // Outside OP and OP-IMM.
            end
        endcase
    end

endmodule

// ==== hdl/regbank.sv ====
module regbank (
    input  logic                               clk,
    input  logic                               reset,
    input  logic [rv_exec_pkg::REG_ADDR_W-1:0] rs1_i,
    input  logic [rv_exec_pkg::REG_ADDR_W-1:0] rs2_i,
    input  logic [rv_exec_pkg::REG_ADDR_W-1:0] rd_i,
    input  logic                               we_i,
    input  logic [rv_exec_pkg::XLEN-1:0]       data_i,
    output logic [rv_exec_pkg::XLEN-1:0]       data1_o,
    output logic [rv_exec_pkg::XLEN-1:0]       data2_o
);
    import rv_exec_pkg::*;

    localparam int NUM_REGS = 2 ** REG_ADDR_W;

    logic [XLEN-1:0] regfile [NUM_REGS];

    assign regfile[0] = '0;  // x0 reads as zero.

    // Combinational reads, old value on same-cycle write.
    assign data1_o = regfile[rs1_i];
    assign data2_o = regfile[rs2_i];

    // One flop row per writable register.
    for (genvar i = 1; i < NUM_REGS; i++) begin : g_reg
        always_ff @(posedge clk) begin
            if (reset) begin
                regfile[i] <= '0;
            end else if (we_i && rd_i == REG_ADDR_W'(i)) begin
                regfile[i] <= data_i;  // Binary index match.
            end
        end
    end

endmodule

// ==== hdl/alu.sv ====
module alu (
    input  rv_exec_pkg::alu_op_e          op_i,
    input  logic [rv_exec_pkg::XLEN-1:0]  a_i,
    input  logic [rv_exec_pkg::XLEN-1:0]  b_i,
    output logic [rv_exec_pkg::XLEN-1:0]  y_o
);
    import rv_exec_pkg::*;

    logic [4:0] shamt;       // Low five bits only.
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt       = b_i[4:0];
    assign lt_signed   = $signed(a_i) < $signed(b_i);
    assign lt_unsigned = a_i < b_i;

    always_comb begin
        case (op_i)
            ALU_ADD:  y_o = a_i + b_i;
            ALU_SUB:  y_o = a_i - b_i;
            ALU_SLL:  y_o = a_i << shamt;
            ALU_SLT:  y_o = {{(XLEN-1){1'b0}}, lt_signed};    // 0 or 1.
            ALU_SLTU: y_o = {{(XLEN-1){1'b0}}, lt_unsigned};
            ALU_XOR:  y_o = a_i ^ b_i;
            ALU_SRL:  y_o = a_i >> shamt;
            ALU_SRA:  y_o = $unsigned($signed(a_i) >>> shamt);  // Sign fill.
            ALU_OR:   y_o = a_i | b_i;
            ALU_AND:  y_o = a_i & b_i;
            default:  y_o = '0;  // Unused codes.
        endcase
    end

endmodule

// ==== hdl/exec_control.sv ====
module exec_control #(
    parameter int RESULT_CREDITS = 2
) (
    input  logic clk,
    input  logic reset,
    input  logic head_empty_i,
    input  logic result_credit_i,
    output logic pop_o,
    output logic advance_o,
    output logic dec_valid_o,
    output logic instr_credit_o
);

    localparam int CNT_W = $clog2(RESULT_CREDITS + 1);

    logic             dec_valid;   // Decode stage occupied.
    logic [CNT_W-1:0] credit_cnt;  // Downstream credits held.
    logic             has_credit;

    assign has_credit = (credit_cnt != '0);

    // Strobes come from registered state only.
    assign advance_o      = dec_valid && has_credit;
    assign pop_o          = !head_empty_i && (!dec_valid || advance_o);
    assign instr_credit_o = pop_o;  // Slot freed upstream.
    assign dec_valid_o    = dec_valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            dec_valid <= 1'b0;
        end else if (pop_o) begin
            dec_valid <= 1'b1;  // Refill, even while advancing.
        end else if (advance_o) begin
            dec_valid <= 1'b0;  // Drained.
        end
    end

    // Spend on advance, gain on return, both in one cycle nets zero.
    always_ff @(posedge clk) begin
        if (reset) begin
            credit_cnt <= CNT_W'(RESULT_CREDITS);
        end else begin
            case ({advance_o, result_credit_i})
                2'b10:   credit_cnt <= credit_cnt - 1'b1;
                2'b01:   credit_cnt <= credit_cnt + 1'b1;
                default: credit_cnt <= credit_cnt;
            endcase
        end
    end

endmodule

// ==== hdl/rv_exec_top.sv ====
module rv_exec_top #(
    parameter int INSTR_DEPTH    = 4,
    parameter int RESULT_CREDITS = 2
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     instr_valid_i,
    input  rv_exec_pkg::instr_word_u instr_i,
    output logic                     instr_credit_o,
    output logic                     result_valid_o,
    output rv_exec_pkg::result_t     result_o,
    input  logic                     result_credit_i
);
    import rv_exec_pkg::*;

    instr_word_u     head;
    logic            q_empty;
    decoded_op_t     dec;       // Decoder output at the head.
    decoded_op_t     dec_q;     // Decode-stage register.
    logic            pop;
    logic            advance;
    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;
    logic [XLEN-1:0] alu_b;
    logic [XLEN-1:0] alu_y;
    logic            rd_write;  // Legal and not x0.
    logic            bank_we;

    instr_queue #(.INSTR_DEPTH(INSTR_DEPTH)) u_queue (
        .clk(clk), .reset(reset), .push_i(instr_valid_i), .data_i(instr_i),
        .pop_i(pop), .head_o(head), .empty_o(q_empty)
    );

    instr_decoder u_decoder (.instr_i(head), .dec_o(dec));

    exec_control #(.RESULT_CREDITS(RESULT_CREDITS)) u_control (
        .clk(clk), .reset(reset), .head_empty_i(q_empty), .result_credit_i(result_credit_i),
        .pop_o(pop), .advance_o(advance), .dec_valid_o(),
        .instr_credit_o(instr_credit_o)
    );

    regbank u_regbank (
        .clk(clk), .reset(reset), .rs1_i(dec_q.rs1), .rs2_i(dec_q.rs2), .rd_i(dec_q.rd),
        .we_i(bank_we), .data_i(alu_y), .data1_o(rs1_data), .data2_o(rs2_data)
    );

    assign alu_b = dec_q.use_imm ? dec_q.imm : rs2_data;  // I or R form.

    alu u_alu (.op_i(dec_q.op), .a_i(rs1_data), .b_i(alu_b), .y_o(alu_y));

    assign rd_write = !dec_q.illegal && (dec_q.rd != '0);
    assign bank_we  = advance && rd_write;  // Same edge as result.

    // Decode stage loads on pop, holds under back-pressure.
    always_ff @(posedge clk) begin
        if (reset) begin
            dec_q <= '0;
        end else if (pop) begin
            dec_q <= dec;
        end
    end

    // Result register, one valid cycle per advance.
    always_ff @(posedge clk) begin
        if (reset) begin
            result_valid_o <= 1'b0;
            result_o       <= '0;
        end else begin
            result_valid_o <= advance;
            if (advance) begin
                result_o.rd      <= dec_q.rd;
                result_o.value   <= rd_write ? alu_y : '0;  // Zero for x0 and illegal.
                result_o.illegal <= dec_q.illegal;
            end
        end
    end

endmodule

// ==== testbench/clock_gen.sv ====
module clock_gen #(
    parameter int PERIOD = 100
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;  // Low at time zero.
    end

    always #(PERIOD / 2) clk_o = ~clk_o;  // Half period per phase.

endmodule

// ==== testbench/rv_exec_chk.sv ====
module rv_exec_chk #(
    parameter int RESULT_CREDITS = 2
) (
    input logic                                   clk,
    input logic                                   reset,
    input logic                                   advance_i,       // Launches result_valid_o.
    input logic                                   instr_credit_i,
    input logic                                   dec_valid_i,
    input logic                                   result_credit_i,
    input logic [$clog2(RESULT_CREDITS + 1)-1:0]  credit_cnt_i
);

    // No record leaves while the count is zero.
    a_send_needs_credit: assert property (
        @(posedge clk) disable iff (reset)
            (credit_cnt_i == '0) && !result_credit_i |=> (credit_cnt_i == '0)
    ) else $error("result launched with zero downstream credits");

    // Counter bounded by the initial credit grant.
    a_credit_bound: assert property (
        @(posedge clk) disable iff (reset) credit_cnt_i <= RESULT_CREDITS
    ) else $error("downstream credit count above its maximum");

    // Quiet strobes right after reset.
    a_quiet_after_reset: assert property (
        @(posedge clk) reset |=> (!advance_i && !instr_credit_i && !dec_valid_i)
    ) else $error("control strobes active in the cycle after reset");

endmodule

// ==== testbench/rv_exec_tb.sv ====
module rv_exec_tb;
    import rv_exec_pkg::*;

    localparam int INSTR_DEPTH    = 4;
    localparam int RESULT_CREDITS = 2;
    localparam int WAIT_LIMIT     = 2000;  // Cycles per bounded wait.

    logic            clk;
    logic            reset;
    logic            instr_valid_i;
    instr_word_u     instr_i;
    logic            instr_credit_o;
    logic            result_valid_o;
    result_t         result_o;
    logic            result_credit_i;
    logic [XLEN-1:0] model_regs [32];     // Architectural register model.
    result_t         exp_q [$];           // Expected records, in order.
    logic [31:0]     main_seed = 32'he8ed;
    logic [31:0]     ds_seed;             // Downstream stream.
    int              up_credits;          // Upstream view of queue space.
    int              held;                // Downstream credits not yet returned.
    int              stretch;
    logic            bp_mode;
    logic            withhold;
    int              checks;
    int              errors;
    int              test_checks;
    int              test_errors;
    int              tests_run;
    int              results_seen;
    string           cur_test;

    clock_gen #(.PERIOD(100)) u_clk (.clk_o(clk));

    rv_exec_top #(.INSTR_DEPTH(INSTR_DEPTH), .RESULT_CREDITS(RESULT_CREDITS)) dut (
        .clk(clk), .reset(reset), .instr_valid_i(instr_valid_i), .instr_i(instr_i),
        .instr_credit_o(instr_credit_o), .result_valid_o(result_valid_o),
        .result_o(result_o), .result_credit_i(result_credit_i)
    );

    bind exec_control rv_exec_chk #(.RESULT_CREDITS(RESULT_CREDITS)) u_chk (
        .clk(clk), .reset(reset), .advance_i(advance_o), .instr_credit_i(instr_credit_o),
        .dec_valid_i(dec_valid_o), .result_credit_i(result_credit_i),
        .credit_cnt_i(credit_cnt)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] s;
        s = x ^ (x << 13);
        s = s ^ (s >> 17);
        return s ^ (s << 5);
    endfunction

    function automatic logic [31:0] next_rand();
        main_seed = xorshift(main_seed);
        return main_seed;
    endfunction

    function automatic instr_word_u make_r(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        instr_word_u w;
        w.r = '{f7, rs2, rs1, f3, rd, OPC_OP};
        return w;
    endfunction

    function automatic instr_word_u make_i(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd);
        instr_word_u w;
        w.i = '{imm, rs1, f3, rd, OPC_OP_IMM};
        return w;
    endfunction

    // RV32I OP and OP-IMM semantics, updates the register model.
    function automatic result_t model_exec(input instr_word_u w);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] y;
        logic        alt;  // SUB or SRA variant.
        logic        bad;
        result_t     r;
        a   = model_regs[w.r.rs1];
        b   = '0;
        y   = '0;
        alt = 1'b0;
        bad = 1'b1;  // Any other opcode.
        if (w.r.opcode == OPC_OP) begin
            b   = model_regs[w.r.rs2];
            alt = (w.r.funct7 == 7'h20);
            bad = alt ? !(w.r.funct3 inside {3'b000, 3'b101}) : (w.r.funct7 != 7'h00);
        end else if (w.i.opcode == OPC_OP_IMM) begin
            b   = {{20{w.i.imm12[11]}}, w.i.imm12};  // Sign-extended immediate.
            alt = w.i.imm12[10];
            bad = 1'b0;
            if (w.i.funct3 == 3'b001) bad = (w.i.imm12[11:5] != 7'h00);
            if (w.i.funct3 == 3'b101) bad = !(w.i.imm12[11:5] inside {7'h00, 7'h20});
        end
        case (w.r.funct3)
            3'b000: y = (alt && w.r.opcode == OPC_OP) ? a - b : a + b;  // No SUBI.
            3'b001: y = a << b[4:0];
            3'b010: y = {31'b0, $signed(a) < $signed(b)};
            3'b011: y = {31'b0, a < b};
            3'b100: y = a ^ b;
            3'b101: begin
                if (alt) y = $unsigned($signed(a) >>> b[4:0]);
                else     y = a >> b[4:0];
            end
            3'b110: y = a | b;
            default: y = a & b;
        endcase
        r.rd      = w.r.rd;
        r.illegal = bad;
        r.value   = (bad || w.r.rd == 5'd0) ? '0 : y;
        if (!bad && w.r.rd != 5'd0) model_regs[w.r.rd] = y;
        return r;
    endfunction

    // Legal word, kind 1 is R-type, 2 is I-type, 0 either.
    function automatic instr_word_u rand_legal(input int kind);
        logic [31:0] r;
        logic [2:0]  f3;
        logic [11:0] imm;
        r  = next_rand();
        f3 = r[2:0];
        if (kind == 1 || (kind == 0 && r[3])) begin
            return make_r((r[4] && f3 inside {3'b000, 3'b101}) ? 7'h20 : 7'h00,
                          r[9:5], r[14:10], f3, r[19:15]);
        end
        imm = r[31:20];
        if (f3 == 3'b001) imm = {7'h00, r[24:20]};  // SLLI.
        else if (f3 == 3'b101) imm = {r[4] ? 7'h20 : 7'h00, r[24:20]};  // SRLI or SRAI.
        return make_i(imm, r[14:10], f3, r[19:15]);
    endfunction

    task automatic report_error(input string msg);
        errors++;
        test_errors++;
        $display("ERROR %s: %s", cur_test, msg);
    endtask

    task automatic check_result(input result_t exp, input result_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            test_errors++;
            $display("FAIL %s: expected rd=%0d value=%h illegal=%b, actual rd=%0d value=%h illegal=%b",
                     cur_test, exp.rd, exp.value, exp.illegal, act.rd, act.value, act.illegal);
        end
    endtask

    task automatic check_count(input string what, input int exp, input int act);
        checks++;
        if (act != exp) begin
            errors++;
            test_errors++;
            $display("FAIL %s: %s expected %0d, actual %0d", cur_test, what, exp, act);
        end
    endtask

    // Called at a rising edge, returns at the next edge after driving.
    task automatic send_word(input instr_word_u w);
        int waited;
        waited = 0;
        while (up_credits == 0 && waited < WAIT_LIMIT) begin
            instr_valid_i <= 1'b0;
            @(posedge clk);
            waited++;
        end
        if (up_credits == 0) begin
            report_error("timed out waiting for an instruction credit");
        end else begin
            instr_valid_i <= 1'b1;
            instr_i       <= w;
            up_credits--;
            exp_q.push_back(model_exec(w));  // Expected at send time.
            @(posedge clk);
        end
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        instr_valid_i <= 1'b0;
        while (exp_q.size() != 0 && waited < WAIT_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        if (exp_q.size() != 0) begin
            report_error($sformatf("timed out with %0d result records missing", exp_q.size()));
        end
        repeat (4) @(posedge clk);  // Room for stray records.
    endtask

    task automatic begin_test(input string name);
        cur_test    = name;
        test_checks = checks;
        test_errors = 0;
    endtask

    task automatic end_test();
        tests_run++;
        $display("test %-13s done: %0d checks, %0d errors", cur_test, checks - test_checks,
                 test_errors);
    endtask

    // Downstream side and credit monitor, samples at the falling edge.
    initial begin
        logic ret;
        result_credit_i = 1'b0;
        ds_seed         = xorshift(32'he8ed);
        held            = 0;
        stretch         = 0;
        withhold        = 1'b0;
        forever begin
            @(negedge clk);
            if (!reset) begin
                if (instr_credit_o === 1'b1) up_credits++;
                if (result_valid_o === 1'b1) begin
                    results_seen++;
                    held++;
                    if (exp_q.size() == 0) begin
                        report_error("result record arrived with no instruction outstanding");
                    end else begin
                        check_result(exp_q.pop_front(), result_o);
                    end
                end
            end
            ds_seed = xorshift(ds_seed);
            if (!bp_mode) begin
                withhold = 1'b0;
            end else if (stretch == 0) begin
                withhold = !withhold;  // New random stretch.
                stretch  = 10 + int'(ds_seed[9:5]);
            end else begin
                stretch--;
            end
            ret = (held > 0) && !withhold && (ds_seed[1:0] != 2'b00);
            @(posedge clk);
            result_credit_i <= ret;
            if (ret) held--;
        end
    end

    initial begin
        logic [31:0] rv;
        logic [6:0]  f7;
        logic [2:0]  f3;
        logic [4:0]  prev_rd;
        instr_word_u w;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        reset         = 1'b1;
        up_credits    = INSTR_DEPTH;
        bp_mode       = 1'b0;
        checks        = 0;
        errors        = 0;
        tests_run     = 0;
        results_seen  = 0;
        cur_test      = "reset";
        foreach (model_regs[k]) model_regs[k] = '0;
        repeat (4) @(posedge clk);
        reset <= 1'b0;

        begin_test("reset_state");
        repeat (10) @(posedge clk);
        check_count("results before first instruction", 0, results_seen);
        send_word(make_r(7'h00, 5'd3, 5'd2, 3'b000, 5'd1));  // ADD x1,x2,x3.
        send_word(make_i(12'h000, 5'd5, 3'b110, 5'd4));      // ORI x4,x5,0.
        drain();
        end_test();

        begin_test("r_type");
        for (int r = 1; r < 32; r++) begin
            rv = next_rand();
            send_word(make_i(rv[11:0], 5'd0, 3'b000, 5'(r)));  // ADDI seed.
        end
        repeat (200) send_word(rand_legal(1));
        drain();
        end_test();

        begin_test("i_type");
        send_word(make_i(12'h800, 5'd0, 3'b000, 5'd5));  // ADDI x5,x0,-2048.
        send_word(make_i(12'h403, 5'd5, 3'b101, 5'd6));  // SRAI by 3.
        send_word(make_i(12'h01f, 5'd5, 3'b101, 5'd7));  // SRLI by 31.
        send_word(make_i(12'h014, 5'd5, 3'b001, 5'd8));  // SLLI by 20.
        for (int n = 0; n < 150; n++) begin
            w = rand_legal(2);
            if (n % 4 == 0 && !(w.i.funct3 inside {3'b001, 3'b101})) begin
                w.i.imm12 = n[2] ? 12'h800 : 12'h7ff;  // Immediate extremes.
            end
            send_word(w);
        end
        drain();
        end_test();

        begin_test("x0_and_deps");
        send_word(make_i(12'h005, 5'd1, 3'b000, 5'd0));  // ADDI x0,x1,5.
        send_word(make_r(7'h00, 5'd0, 5'd0, 3'b000, 5'd9));
        repeat (20) send_word(make_i(12'h001, 5'd10, 3'b000, 5'd10));  // Tight chain.
        prev_rd = 5'd10;
        for (int n = 0; n < 40; n++) begin
            w       = rand_legal(0);
            w.r.rs1 = prev_rd;  // Same bits in both formats.
            send_word(w);
            prev_rd = w.r.rd;
        end
        drain();
        end_test();

        begin_test("illegal");
        for (int n = 0; n < 60; n++) begin
            rv = next_rand();
            case (rv[1:0])
                2'd0, 2'd1: begin
                    w = instr_word_u'(rv);
                    if (w.r.opcode == OPC_OP || w.r.opcode == OPC_OP_IMM) w.r.opcode[2] = 1'b1;
                end
                2'd2: begin
                    f7 = rv[31:25];
                    if (f7 == 7'h00 || f7 == 7'h20) f7 = 7'h01;
                    w = make_r(f7, rv[24:20], rv[19:15], rv[14:12], rv[11:7]);
                end
                default: begin
                    f3 = rv[14:12];
                    if (f3 inside {3'b000, 3'b101}) f3 = 3'b111;
                    w = rv[5] ? make_r(7'h20, rv[24:20], rv[19:15], f3, rv[11:7])
                              : make_i({7'h20, rv[24:20]}, rv[19:15], 3'b001, rv[11:7]);
                end
            endcase
            send_word(w);
            send_word(make_r(7'h00, 5'd0, w.r.rd, 3'b000, w.r.rd));  // Read rd back.
        end
        drain();
        end_test();

        begin_test("back_pressure");
        bp_mode = 1'b1;
        for (int n = 0; n < 150; n++) begin
            send_word(rand_legal(0));
            rv = next_rand();
            if (rv[2:0] == 3'b000) begin
                instr_valid_i <= 1'b0;  // Upstream gap.
                @(posedge clk);
            end
        end
        bp_mode = 1'b0;
        drain();
        check_count("upstream credits after drain", INSTR_DEPTH, up_credits);
        end_test();

        $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// ==== project.f ====
hdl/rv_exec_pkg.sv
hdl/instr_queue.sv
hdl/instr_decoder.sv
hdl/regbank.sv
hdl/alu.sv
hdl/exec_control.sv
hdl/rv_exec_top.sv
testbench/clock_gen.sv
testbench/rv_exec_chk.sv
testbench/rv_exec_tb.sv
